// ==== noc_settings.svh ====
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// number of input ports competing for the output link, fixed by the one-hot grant state
`define NOC_PORTS 5

`define FLIT_W 32      // flit payload width

// packet length, also the width of the packet timer count
`define LEN_W 12

`define FLIT_ID_W 3    // flit type field

`endif

// ==== nocPkg.sv ====
`default_nettype none

`include "noc_settings.svh"

package nocPkg;

  // one-hot allocator state, bit 0 is idle and bit p+1 belongs to input port p
  typedef enum logic [`NOC_PORTS:0] {
    gIdle  = 6'b000001,
    gLocal = 6'b000010,
    gNorth = 6'b000100,
    gEast  = 6'b001000,
    gWest  = 6'b010000,
    gSouth = 6'b100000
  } grantT;

  // flit type carried alongside every flit
  typedef enum logic [`FLIT_ID_W-1:0] {
    fidNone = 3'd0,
    fidHead = 3'd1,   // only a header reloads the packet timer
    fidBody = 3'd2,
    fidTail = 3'd3
  } flitIdT;

endpackage

`default_nettype wire

// ==== nocLinkIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

interface nocLinkIf import nocPkg::*; ();

  logic              req;     // plain level, no handshake
  flitIdT            flitId;
  logic [`LEN_W-1:0] length;
  logic [`FLIT_W-1:0] flit;

  modport drive (output req, output flitId, output length, output flit);

  modport arb (input req, input flitId, input length);

  // the selector also forwards the flit type onto the output link
  modport sel (input req, input flitId, input flit);

endinterface

`default_nettype wire

// ==== packetTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module packetTimer import nocPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  flitIdT            flitId,
  input  logic [`LEN_W-1:0] length,
  input  logic              run,
  output logic              timesUp
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // a header reloads the limit even when this port is not granted
      if (flitId == fidHead)
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;   // back to zero whenever the port does not hold the link
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// ==== outputArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module outputArbiter import nocPkg::*; (
  input  logic  clk,
  input  logic  rst,
  nocLinkIf.arb lnk [`NOC_PORTS],
  output grantT grant
);

  logic [`NOC_PORTS-1:0] reqV;
  logic [`NOC_PORTS-1:0] run;
  logic [`NOC_PORTS-1:0] timesUp;
  grantT                 nextGrant;
  int                    cur;

  // first requesting port among span ports, starting at port first and wrapping round
  function automatic grantT pickFrom(
    input logic [`NOC_PORTS-1:0] reqs,
    input int                    first,
    input int                    span
  );
    grantT pick;
    int    idx;
    pick = gIdle;
    // walk backwards so the earliest port in the order is the one left standing
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = first + k;
      if (idx >= `NOC_PORTS)
        idx = idx - `NOC_PORTS;
      if (reqs[idx])
        pick = grantT'({{`NOC_PORTS{1'b0}}, 1'b1} << (idx + 1));
    end
    return pick;
  endfunction

  genvar i;
  generate
    for (i = 0; i < `NOC_PORTS; i++)
    begin : gPort
      assign reqV[i] = lnk[i].req;

      packetTimer timer (
        .clk     (clk),
        .rst     (rst),
        .flitId  (lnk[i].flitId),
        .length  (lnk[i].length),
        .run     (run[i]),
        .timesUp (timesUp[i])
      );
    end
  endgenerate

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= gIdle;
    else
      grant <= nextGrant;
  end

  always_comb
  begin
    nextGrant = gIdle;
    run = '0;
    cur = 0;
    // port index of the current owner, meaningful only in a port state
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p + 1])
        cur = p;
    end
    case (grant)
      gIdle:
        begin
          nextGrant = pickFrom(reqV, 0, `NOC_PORTS);   // fixed order L, N, E, W, S
        end
      gLocal, gNorth, gEast, gWest, gSouth:
        begin
          if (reqV[cur] && !timesUp[cur])
          begin
            run[cur] = 1'b1;
            nextGrant = grant;
          end
          else
          begin
            // owner is left out, so a lone requester falls through idle first
            nextGrant = pickFrom(reqV, cur + 1, `NOC_PORTS - 1);
          end
        end
      default:
        begin
          nextGrant = gIdle;
        end
    endcase
  end

endmodule

`default_nettype wire

// ==== flitSelector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module flitSelector import nocPkg::*; (
  input  logic               clk,
  input  logic               rst,
  nocLinkIf.sel              lnk [`NOC_PORTS],
  input  grantT              grant,
  output logic               outValid,
  output logic [`FLIT_W-1:0] outFlit,
  output flitIdT             outFlitId
);

  logic [`NOC_PORTS-1:0] reqV;
  logic [`FLIT_W-1:0]    flitV [`NOC_PORTS];
  flitIdT                idV [`NOC_PORTS];
  logic                  selValid;
  logic [`FLIT_W-1:0]    selFlit;
  flitIdT                selId;

  genvar i;
  generate
    for (i = 0; i < `NOC_PORTS; i++)
    begin : gPort
      assign reqV[i]  = lnk[i].req;
      assign flitV[i] = lnk[i].flit;
      assign idV[i]   = lnk[i].flitId;
    end
  endgenerate

  // one-hot mux, idle selects nothing and yields an empty flit
  always_comb
  begin
    selValid = 1'b0;
    selFlit = '0;
    selId = fidNone;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grant[p + 1])
      begin
        selValid = reqV[p];
        selFlit = flitV[p];
        selId = idV[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outFlitId <= selId;   // payload follows the grant one cycle later
  end

endmodule

`default_nettype wire

// ==== routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module routerOutputPort import nocPkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [`NOC_PORTS-1:0] req,
  input  flitIdT             flitId [`NOC_PORTS],
  input  logic [`LEN_W-1:0]  length [`NOC_PORTS],
  input  logic [`FLIT_W-1:0] flit [`NOC_PORTS],
  output grantT              grant,
  output logic               outValid,
  output logic [`FLIT_W-1:0] outFlit,
  output flitIdT             outFlitId
);

  // one link per input port, index order L, N, E, W, S
  nocLinkIf link [`NOC_PORTS] ();

  genvar i;
  generate
    for (i = 0; i < `NOC_PORTS; i++)
    begin : gLink
      assign link[i].req    = req[i];
      assign link[i].flitId = flitId[i];
      assign link[i].length = length[i];
      assign link[i].flit   = flit[i];
    end
  endgenerate

  outputArbiter arbiter (
    .clk   (clk),
    .rst   (rst),
    .lnk   (link),
    .grant (grant)
  );

  // grant feeds the selector directly, so the output trails it by one cycle
  flitSelector selector (
    .clk       (clk),
    .rst       (rst),
    .lnk       (link),
    .grant     (grant),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outFlitId (outFlitId)
  );

endmodule

`default_nettype wire

// ==== routerOutputPort_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module routerOutputPort_assert import nocPkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic [`NOC_PORTS-1:0] req,
  input grantT                 grant,
  input logic                  outValid,
  input logic [`NOC_PORTS-1:0] timesUp
);

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot: %b", grant);

  // an idle allocator forwards nothing on the next cycle
  idleNoValid: assert property (@(posedge clk) disable iff (rst)
    (grant == gIdle) |=> !outValid)
    else $error("outValid is high one cycle after an idle grant");

  genvar p;
  generate
    for (p = 0; p < `NOC_PORTS; p++)
    begin : gHold
      holdUntilTimer: assert property (@(posedge clk) disable iff (rst)
        (grant[p + 1] && req[p] && !timesUp[p]) |=> grant[p + 1])
        else $error("grant left port %0d before its packet timer was up", p);
    end
  endgenerate

endmodule

`default_nettype wire

// ==== tb_routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_settings.svh"

module tb_routerOutputPort import nocPkg::*; ();

  localparam int maxCases = 64;

  logic                  clk;
  logic                  rst;
  logic [`NOC_PORTS-1:0] req;
  flitIdT                flitId [`NOC_PORTS];
  logic [`LEN_W-1:0]     length [`NOC_PORTS];
  logic [`FLIT_W-1:0]    flit [`NOC_PORTS];
  grantT                 grant;
  logic                  outValid;
  logic [`FLIT_W-1:0]    outFlit;
  flitIdT                outFlitId;

  logic [8*16-1:0]       caseName [maxCases];
  logic [`NOC_PORTS-1:0] caseReq [maxCases];
  logic [`NOC_PORTS-1:0] caseHead [maxCases];
  logic [`LEN_W-1:0]     caseLen [maxCases];
  logic [`NOC_PORTS:0]   caseGrant [maxCases];
  logic [`NOC_PORTS:0]   expPrev;   // expected grant before the current edge
  logic [8*16-1:0]       resetName;
  logic [31:0]           lfsr;
  logic                  loaded;
  int                    nCases;
  int                    errors;
  int                    checks;
  int                    cycles;
  int                    cycleLimit;

  routerOutputPort uut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .flitId    (flitId),
    .length    (length),
    .flit      (flit),
    .grant     (grant),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outFlitId (outFlitId)
  );

  bind routerOutputPort routerOutputPort_assert asserts (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .grant    (grant),
    .outValid (outValid),
    .timesUp  (arbiter.timesUp)
  );

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] shiftLfsr(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  task automatic randomFlit(output logic [`FLIT_W-1:0] value);
    value = '0;
    for (int b = 0; b < `FLIT_W; b++)
    begin
      lfsr = shiftLfsr(lfsr);
      value = {value[`FLIT_W-2:0], lfsr[0]};
    end
  endtask

  task automatic compareValue(
    input logic [8*16-1:0] testName,
    input string           what,
    input logic [31:0]     expected,
    input logic [31:0]     actual
  );
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("Error %0s %0s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic loadCases();
    int              fd;
    int              got;
    string           line;
    logic [8*16-1:0] nm;
    logic [31:0]     r;
    logic [31:0]     h;
    logic [31:0]     l;
    logic [31:0]     g;
    nCases = 0;
    fd = $fopen("routerOutputPort_cases.txt", "r");
    if (fd == 0)
      $display("could not open routerOutputPort_cases.txt");
    else
    begin
      while (!$feof(fd) && nCases < maxCases)
      begin
        got = $fgets(line, fd);
        // comment lines never scan as five fields
        if (got > 0 && $sscanf(line, "%s %h %h %h %h", nm, r, h, l, g) == 5)
        begin
          caseName[nCases] = nm;
          caseReq[nCases] = r[`NOC_PORTS-1:0];
          caseHead[nCases] = h[`NOC_PORTS-1:0];
          caseLen[nCases] = l[`LEN_W-1:0];
          caseGrant[nCases] = g[`NOC_PORTS:0];
          nCases++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic applyCase(input int k);
    logic [`FLIT_W-1:0] word;
    req = caseReq[k];
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      randomFlit(word);
      flit[p] = word;
      length[p] = caseLen[k];   // only a header lets the timer take it
      if (caseHead[k][p])
        flitId[p] = fidHead;
      else if (caseReq[k][p])
        flitId[p] = fidBody;
      else
        flitId[p] = fidNone;
    end
  endtask

  // the output register shows the inputs of this cycle for the port granted before the edge
  task automatic checkCycle(input int k, input logic [`NOC_PORTS:0] prevGrant);
    logic expValid;
    int   owner;
    expValid = 1'b0;
    owner = -1;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (prevGrant[p + 1])
        owner = p;
    end
    compareValue(caseName[k], "grant", 32'(caseGrant[k]), 32'(grant));
    if (owner >= 0)
      expValid = req[owner];
    compareValue(caseName[k], "outValid", 32'(expValid), 32'(outValid));
    if (owner >= 0)
    begin
      compareValue(caseName[k], "outFlit", flit[owner], outFlit);
      compareValue(caseName[k], "outFlitId", 32'(flitId[owner]), 32'(outFlitId));
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      flitId[p] = fidNone;
      length[p] = '0;
      flit[p] = '0;
    end
    lfsr = 32'hc523;
    errors = 0;
    checks = 0;
    loaded = 1'b0;
    resetName = {88'b0, "reset"};
    loadCases();
    cycleLimit = nCases + 20;
    loaded = 1'b1;
    if (nCases == 0)
    begin
      $display("no test cases were read from routerOutputPort_cases.txt");
      $display("** FAIL **");
    end
    else
    begin
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      compareValue(resetName, "grant", 32'(gIdle), 32'(grant));
      compareValue(resetName, "outValid", 32'(1'b0), 32'(outValid));
      expPrev = gIdle;
      for (int k = 0; k < nCases; k++)
      begin
        applyCase(k);
        @(negedge clk);
        checkCycle(k, expPrev);
        expPrev = caseGrant[k];
      end
      $display("%0d cases, %0d checks, %0d errors", nCases, checks, errors);
      if (errors == 0)
        $display("** PASS **");
      else
        $display("** FAIL **");
    end
    $finish;
  end

  initial
  begin
    cycles = 0;
    wait (loaded === 1'b1);
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the test sequence did not finish", cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
nocPkg.sv
nocLinkIf.sv
packetTimer.sv
outputArbiter.sv
flitSelector.sv
routerOutputPort.sv
routerOutputPort_assert.sv
tb_routerOutputPort.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_routerOutputPort \
  -f list.f \
  -o simRouter

./obj_dir/simRouter > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== routerOutputPort_cases.txt ====
# name, request mask, header mask, header length, expected grant after the edge
# masks and grant in hex, bit 0 is Local and bit 4 South, grant bit 0 is idle
idle     00 00 000 01
idle     00 00 000 01
rotate   1f 00 000 02
rotate   1f 00 000 04
rotate   1f 00 000 08
rotate   1f 00 000 10
rotate   1f 00 000 20
rotate   1f 00 000 02
rotate   1b 00 000 04
rotate   1b 00 000 10
rotate   00 00 000 01
hold     02 02 003 04
hold     02 00 000 04
hold     02 00 000 04
hold     02 00 000 04
hold     02 00 000 01
hold     02 00 000 04
drop     10 00 000 20
drop     10 00 000 01
drop     10 00 000 20
preload  10 04 002 01
preload  04 00 000 08
preload  04 00 000 08
preload  04 00 000 08
preload  04 00 000 01
preload  00 00 000 01
handoff  03 01 001 02
handoff  03 00 000 02
handoff  03 00 000 04
handoff  00 00 000 01
